//--- files.f
+incdir+common
common/rv_isa_pkg.sv
common/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/pc_gen.sv
rtl/branch_predecode.sv
fetch_buffer/fetch_buffer.sv
rtl/fetch_top.sv
dv/fetch_clkgen.sv
dv/fetch_props.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module fetch_tb -o Vfetch_tb

out="$(./obj_dir/Vfetch_tb)"
echo "$out"

if grep -qx "RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1

//--- dv/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;

    localparam int PROG_WORDS = 256;
    localparam int ROWS       = 9;

    typedef struct packed {
        int          ofs;     // cycles before the row acts
        int          mode;    // 0 none, 1 redirect now, 2 redirect in a wait state
        logic [31:0] pc;
        int          stall;   // stall cycles with any redirect in the last one
    } stim_row_t;

    logic        clk;
    logic        arst_n;
    logic [31:0] wb_dat = 32'd0;
    logic        wb_ack = 1'b0;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        branch_pred;
    logic [31:0] prog [PROG_WORDS];
    stim_row_t   stim [ROWS];
    logic [31:0] rng = 32'h4f1a1503;
    logic        mem_in_req = 1'b0;
    int          mem_wait = 0;
    int          checks;
    int          errors;
    int          consumed;
    int          prop_fails;

    fetch_clkgen u_clkgen (.o_clk(clk), .o_arst_n(arst_n));

    fetch_top u_fetch_top
    (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_wb_dat      (wb_dat),
        .i_wb_ack      (wb_ack),
        .o_wb_cyc      (wb_cyc),
        .o_wb_stb      (wb_stb),
        .o_wb_adr      (wb_adr),
        .i_stall       (stall),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .o_valid       (valid),
        .o_instr       (instr),
        .o_pc          (pc),
        .o_branch_pred (branch_pred)
    );

    fetch_checker #(.PROG_WORDS(PROG_WORDS)) u_checker
    (
        .i_clk (clk), .i_arst_n (arst_n), .i_prog (prog),
        .i_wb_cyc (wb_cyc), .i_wb_ack (wb_ack), .i_stall (stall),
        .i_redirect (redirect), .i_redirect_pc (redirect_pc), .i_valid (valid),
        .i_instr (instr), .i_pc (pc), .i_branch_pred (branch_pred),
        .o_checks (checks), .o_errors (errors), .o_consumed (consumed)
    );

    bind fetch_top fetch_props u_fetch_props
    (
        .i_clk (i_clk), .i_arst_n (i_arst_n), .i_wb_ack (i_wb_ack),
        .i_wb_cyc (o_wb_cyc), .i_wb_stb (o_wb_stb), .i_wb_adr (o_wb_adr),
        .i_stall (i_stall), .i_redirect (i_redirect), .i_valid (o_valid),
        .i_pc (o_pc), .i_instr (o_instr)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (addr < PROG_WORDS * 4)
            return prog[addr[9:2]];
        return 32'h0000_0013;   // nop outside the image
    endfunction

    // --------------------------------------------------
    // memory model with 0 to 3 wait states per request
    // --------------------------------------------------
    always @(negedge clk)
    begin
        wb_ack = 1'b0;
        if (arst_n && wb_cyc && wb_stb)
        begin
            if (!mem_in_req)   // a new request draws its latency
            begin
                mem_in_req = 1'b1;
                rng        = next_random(rng);
                mem_wait   = int'(rng[1:0]);
            end
            if (mem_wait == 0)
            begin
                wb_ack     = 1'b1;
                wb_dat     = read_word(wb_adr);
                mem_in_req = 1'b0;
            end
            else
                mem_wait = mem_wait - 1;
        end
    end

    // watchdog allows 200 cycles per row plus reset and drain
    initial
    begin
        repeat (ROWS * 200 + 10 + 60) @(posedge clk);
        $display("timeout: stimulus did not finish in the allowed cycles");
        $display("RESULT: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial
    begin
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = 32'd0;
        for (int i = 0; i < PROG_WORDS; i++)
            prog[i] = {i[9:0], 2'b00, 5'd0, 3'b000, 5'd1, 7'b0010011};  // addi x1,x0,addr
        prog[8'h44] = 32'h0000_0863;   // 0x110 beq forward +16
        prog[8'h48] = 32'h0400_006f;   // 0x120 jal +0x40 to 0x160
        prog[8'h5c] = 32'hfe00_18e3;   // 0x170 bne backward -16 to 0x160
        stim[0] = '{40, 0, 32'h0,         0};
        stim[1] = '{30, 0, 32'h0,        25};
        stim[2] = '{10, 1, 32'h0000_0200, 0};
        stim[3] = '{20, 2, 32'h0000_0300, 0};
        stim[4] = '{15, 1, 32'h0000_0104, 20};   // idle with a full buffer
        stim[5] = '{40, 0, 32'h0,         3};
        stim[6] = '{10, 1, 32'h0000_03f0, 0};    // runs past the image
        stim[7] = '{30, 2, 32'h0000_016c, 8};
        stim[8] = '{20, 1, 32'h0000_0110, 0};
        wait (arst_n);
        @(negedge clk);
        for (int r = 0; r < ROWS; r++)
        begin
            repeat (stim[r].ofs) @(negedge clk);
            if (stim[r].stall != 0)
            begin
                stall = 1'b1;
                repeat (stim[r].stall - 1) @(negedge clk);
            end
            if (stim[r].mode == 1)
            begin
                redirect    = 1'b1;
                redirect_pc = stim[r].pc;
            end
            if (stim[r].stall != 0 || stim[r].mode == 1)
                @(negedge clk);
            stall    = 1'b0;
            redirect = 1'b0;
            if (stim[r].mode == 2)
            begin
                @(posedge clk);
                while (!(wb_cyc && mem_in_req && mem_wait != 0))   // next cycle has no ack
                    @(posedge clk);
                @(negedge clk);
                redirect    = 1'b1;
                redirect_pc = stim[r].pc;
                @(negedge clk);
                redirect = 1'b0;
            end
        end
        repeat (60) @(negedge clk);
        prop_fails = u_fetch_top.u_fetch_props.fail_count;
        if (consumed == 0)
            $display("no instruction reached decode during the run");
        $display("checks=%0d consumed=%0d errors=%0d assertion_failures=%0d",
                 checks, consumed, errors + (consumed == 0 ? 1 : 0), prop_fails);
        if (errors == 0 && consumed != 0 && prop_fails == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- dv/fetch_checker.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_checker import rv_isa_pkg::*;
#(
    parameter int PROG_WORDS = 256
)
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  logic [`XLEN-1:0] i_prog [PROG_WORDS],   // program image of the memory
    input  logic             i_wb_cyc,
    input  logic             i_wb_ack,
    input  logic             i_stall,
    input  logic             i_redirect,
    input  logic [`XLEN-1:0] i_redirect_pc,
    input  logic             i_valid,
    input  logic [`XLEN-1:0] i_instr,
    input  logic [`XLEN-1:0] i_pc,
    input  logic             i_branch_pred,
    output int               o_checks,
    output int               o_errors,
    output int               o_consumed
);

    logic [`XLEN-1:0] exp_pc;   // pc decode should see next
    rv_instr_u        word;
    logic             exp_taken;
    logic [`XLEN-1:0] exp_target;
    int               checks;
    int               errors;
    int               consumed;
    int               stall_acks;

    assign o_checks   = checks;
    assign o_errors   = errors;
    assign o_consumed = consumed;

    function automatic logic [`XLEN-1:0] prog_word(input logic [`XLEN-1:0] addr);
        if (addr < PROG_WORDS * 4)
            return i_prog[addr[9:2]];
        return 32'h0000_0013;   // nop past the image
    endfunction

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        checks = checks + 1;
        if (got !== exp)
        begin
            errors = errors + 1;
            $display("[ERROR] %0t %s expected %08h got %08h", $time, name, exp, got);
        end
    endtask

    // --------------------------------------------------
    // expected stream, static prediction per word
    // --------------------------------------------------
    always @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            exp_pc     = `FETCH_RESET_ADDR;
            checks     = 0;
            errors     = 0;
            consumed   = 0;
            stall_acks = 0;
        end
        else
        begin
            if (i_valid && !i_stall)   // head taken at this edge
            begin
                word.raw  = prog_word(exp_pc);
                exp_taken = 1'b0;
                exp_target = exp_pc + 32'd4;
                if (word.j.opcode == OPC_JAL)
                begin
                    exp_taken  = 1'b1;
                    exp_target = exp_pc + {{12{word.j.imm20}}, word.j.imm19_12,
                                           word.j.imm11, word.j.imm10_1, 1'b0};
                end
                else if (word.b.opcode == OPC_BRANCH && word.b.imm12)   // backward only
                begin
                    exp_taken  = 1'b1;
                    exp_target = exp_pc + {{20{1'b1}}, word.b.imm11,
                                           word.b.imm10_5, word.b.imm4_1, 1'b0};
                end
                check_value("o_pc", i_pc, exp_pc);
                check_value("o_instr", i_instr, word.raw);
                check_value("o_branch_pred", {31'd0, i_branch_pred}, {31'd0, exp_taken});
                consumed = consumed + 1;
                exp_pc   = exp_target;
            end
            if (i_redirect)
                exp_pc = i_redirect_pc;   // older words are flushed
            // buffer has 4 slots, so a stall admits at most 4 acks
            if (!i_stall || i_redirect)
                stall_acks = 0;
            else if (i_wb_cyc && i_wb_ack)
            begin
                stall_acks = stall_acks + 1;
                if (stall_acks == 5)
                begin
                    errors = errors + 1;
                    $display("back-pressure broken at %0t, a fifth ack arrived during a stall",
                             $time);
                end
            end
        end
    end

endmodule

//--- dv/fetch_props.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_props
(
    input logic             i_clk,
    input logic             i_arst_n,
    input logic             i_wb_ack,
    input logic             i_wb_cyc,
    input logic             i_wb_stb,
    input logic [`XLEN-1:0] i_wb_adr,
    input logic             i_stall,
    input logic             i_redirect,
    input logic             i_valid,
    input logic [`XLEN-1:0] i_pc,
    input logic [`XLEN-1:0] i_instr
);

    localparam int DEPTH = 1 << `FETCH_BUF_DEPTH_BITS;

    int stall_acks;       // acks since the current stall began
    int fail_count = 0;   // assertion failures so far

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            stall_acks <= 0;
        else if (!i_stall || i_redirect)
            stall_acks <= 0;
        else if (i_wb_cyc && i_wb_ack)
            stall_acks <= stall_acks + 1;
    end

    // --------------------------------------------------
    // wishbone side
    // --------------------------------------------------
    // request held until acked
    adr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_wb_cyc && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr)))
        else
        begin
            $error("wishbone request changed before ack");
            fail_count = fail_count + 1;
        end

    no_cyc_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !i_wb_cyc)
        else
        begin
            $error("wishbone cycle raised during reset");
            fail_count = fail_count + 1;
        end

    // --------------------------------------------------
    // decode side
    // --------------------------------------------------
    head_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_valid && i_stall && !i_redirect) |=> ($stable(i_pc) && $stable(i_instr)))
        else
        begin
            $error("decode head moved while stalled");
            fail_count = fail_count + 1;
        end

    stall_fill: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        stall_acks <= DEPTH)
        else
        begin
            $error("more acks during a stall than buffer entries");
            fail_count = fail_count + 1;
        end

endmodule

//--- dv/fetch_clkgen.sv
`timescale 1ns/1ps

module fetch_clkgen
(
    output logic o_clk,
    output logic o_arst_n
);

    // 10 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // hold reset for 10 cycles, release away from the rising edge
    initial
    begin
        o_arst_n = 1'b0;
        repeat (10) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;
    end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top import fetch_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    // wishbone classic, read only
    input  logic [`XLEN-1:0] i_wb_dat,
    input  logic             i_wb_ack,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output logic [`XLEN-1:0] o_wb_adr,
    // decode and execute
    input  logic             i_stall,
    input  logic             i_redirect,
    input  logic [`XLEN-1:0] i_redirect_pc,
    output logic             o_valid,
    output logic [`XLEN-1:0] o_instr,
    output logic [`XLEN-1:0] o_pc,
    output logic             o_branch_pred
);

    logic [`XLEN-1:0]         fetch_pc;
    logic [`XLEN-1:0]         pred_target;
    logic                     pred_taken;
    fetch_src_e               src;
    logic                     push;
    logic                     pop;
    logic                     buf_clear;
    logic                     buf_full;
    logic                     buf_empty;
    logic [FETCH_ENTRY_W-1:0] push_data;
    logic [FETCH_ENTRY_W-1:0] head_data;
    logic                     head_pred;

    // --------------------------------------------------
    // entry packing and decode handshake
    // --------------------------------------------------
    assign push_data = {fetch_pc, i_wb_dat, pred_taken};
    assign {o_pc, o_instr, head_pred} = head_data;
    assign o_valid       = ~buf_empty;
    assign o_branch_pred = head_pred & ~buf_empty;   // ram content is x after reset
    assign pop           = ~buf_empty & ~i_stall;    // decode takes the head
    assign o_wb_adr      = fetch_pc;

    fetch_ctrl u_fetch_ctrl
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_wb_ack     (i_wb_ack),
        .i_buf_full   (buf_full),
        .i_redirect   (i_redirect),
        .i_pred_taken (pred_taken),
        .o_wb_cyc     (o_wb_cyc),
        .o_wb_stb     (o_wb_stb),
        .o_src        (src),
        .o_push       (push),
        .o_buf_clear  (buf_clear)
    );

    pc_gen u_pc_gen
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_src         (src),
        .i_redirect_pc (i_redirect_pc),
        .i_pred_target (pred_target),
        .o_pc          (fetch_pc)
    );

    branch_predecode u_branch_predecode
    (
        .i_instr       (i_wb_dat),
        .i_pc          (fetch_pc),
        .o_pred_taken  (pred_taken),
        .o_pred_target (pred_target)
    );

    fetch_buffer
    #(
        .DEPTH_BITS (`FETCH_BUF_DEPTH_BITS)
    )
    u_fetch_buffer
    (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_clear  (buf_clear),
        .i_push   (push),
        .i_data   (push_data),
        .i_pop    (pop),
        .o_data   (head_data),
        .o_empty  (buf_empty),
        .o_full   (buf_full)
    );

endmodule

//--- fetch_buffer/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import fetch_pkg::*;
#(
    parameter int DEPTH_BITS = 2
)
(
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  logic                     i_clear,
    input  logic                     i_push,
    input  logic [FETCH_ENTRY_W-1:0] i_data,
    input  logic                     i_pop,
    output logic [FETCH_ENTRY_W-1:0] o_data,
    output logic                     o_empty,
    output logic                     o_full    // full after this edge
);

    logic [FETCH_ENTRY_W-1:0] mem [2**DEPTH_BITS];   // entry ram, no reset

    // msb is the wrap bit, equal lows with different msb means full
    logic [DEPTH_BITS:0] wr_ptr;
    logic [DEPTH_BITS:0] rd_ptr;
    logic [DEPTH_BITS:0] wr_nxt;
    logic [DEPTH_BITS:0] rd_nxt;

    // --------------------------------------------------
    // pointer next state, clear wins over push and pop
    // --------------------------------------------------
    assign wr_nxt = i_clear ? '0 : wr_ptr + {{DEPTH_BITS{1'b0}}, i_push};
    assign rd_nxt = i_clear ? '0 : rd_ptr + {{DEPTH_BITS{1'b0}}, i_pop};

    // looks one edge ahead so a new request always has a free slot
    assign o_full = (wr_nxt[DEPTH_BITS] != rd_nxt[DEPTH_BITS]) &&
                    (wr_nxt[DEPTH_BITS-1:0] == rd_nxt[DEPTH_BITS-1:0]);

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_data  = mem[rd_ptr[DEPTH_BITS-1:0]];   // head, valid when not empty

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            wr_ptr <= wr_nxt;
            rd_ptr <= rd_nxt;
        end
    end

    // push into a full buffer is fine when the head leaves at the same edge
    always_ff @(posedge i_clk)
    begin
        if (i_push && !i_clear)
            mem[wr_ptr[DEPTH_BITS-1:0]] <= i_data;
    end

endmodule

//--- rtl/branch_predecode.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module branch_predecode import rv_isa_pkg::*;
(
    input  logic [`XLEN-1:0] i_instr,        // word on the bus this cycle
    input  logic [`XLEN-1:0] i_pc,           // address it was fetched from
    output logic             o_pred_taken,
    output logic [`XLEN-1:0] o_pred_target
);

    rv_instr_u        instr;
    logic [`XLEN-1:0] imm_b;   // sign extended branch offset
    logic [`XLEN-1:0] imm_j;   // sign extended jump offset

    assign instr = i_instr;

    // --------------------------------------------------
    // immediates, bit 0 is always zero
    // --------------------------------------------------
    assign imm_b = {{(`XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_j = {{(`XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    // --------------------------------------------------
    // static rule, jumps and backward branches taken
    // --------------------------------------------------
    always_comb
    begin
        o_pred_taken  = 1'b0;
        o_pred_target = i_pc + imm_j;   // only meaningful when taken
        case (instr.b.opcode)
            OPC_JAL:
            begin
                o_pred_taken  = 1'b1;
                o_pred_target = i_pc + imm_j;
            end
            OPC_BRANCH:
            begin
                o_pred_taken  = instr.b.imm12;   // negative offset means a loop
                o_pred_target = i_pc + imm_b;
            end
            default:
            begin
                o_pred_taken = 1'b0;   // jalr and the rest fall through
            end
        endcase
    end

endmodule

//--- rtl/pc_gen.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_gen import fetch_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  fetch_src_e       i_src,
    input  logic [`XLEN-1:0] i_redirect_pc,
    input  logic [`XLEN-1:0] i_pred_target,
    output logic [`XLEN-1:0] o_pc
);

    logic [`XLEN-1:0] pc_q;          // address of the current or next request
    logic [`XLEN-1:0] pc_d;
    logic [`XLEN-1:0] pc_seq;
    logic [`XLEN-1:0] redir_q;       // target kept until the bus is free
    logic             redir_pend_q;

    assign pc_seq = pc_q + `XLEN'(4);

    // a parked redirect replaces whatever fetch would do next
    always_comb
    begin
        case (i_src)
            SRC_SEQ:  pc_d = redir_pend_q ? redir_q : pc_seq;
            SRC_PRED: pc_d = redir_pend_q ? redir_q : i_pred_target;
            default:  pc_d = pc_q;   // hold, adr must not move mid cycle
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_src == SRC_REDIR)
            redir_q <= i_redirect_pc;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pc_q         <= `FETCH_RESET_ADDR;
            redir_pend_q <= 1'b0;
        end
        else
        begin
            pc_q <= pc_d;
            if (i_src == SRC_REDIR)
                redir_pend_q <= 1'b1;
            else if (i_src != SRC_HOLD)
                redir_pend_q <= 1'b0;   // consumed by the load above
        end
    end

    assign o_pc = pc_q;

endmodule

//--- rtl/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_wb_ack,
    input  logic       i_buf_full,    // buffer full as of the next edge
    input  logic       i_redirect,
    input  logic       i_pred_taken,
    output logic       o_wb_cyc,
    output logic       o_wb_stb,
    output fetch_src_e o_src,
    output logic       o_push,
    output logic       o_buf_clear
);

    logic busy_q;      // a wishbone read is outstanding
    logic busy_d;
    logic discard_q;   // redirect seen, target parked in pc_gen
    logic discard_d;
    logic ack_seen;

    assign ack_seen = busy_q & i_wb_ack;

    // --------------------------------------------------
    // buffer side
    // --------------------------------------------------
    // stale data from before a redirect never reaches decode
    assign o_push      = ack_seen & ~discard_q & ~i_redirect;
    assign o_buf_clear = i_redirect;      // flush queued words at once

    // --------------------------------------------------
    // request sequencing and next pc source
    // --------------------------------------------------
    always_comb
    begin
        busy_d    = busy_q;
        discard_d = discard_q;
        o_src     = SRC_HOLD;                 // adr stays put by default
        if (i_redirect)
        begin
            o_src     = SRC_REDIR;            // pc_gen parks the target
            discard_d = 1'b1;
            if (ack_seen)
                busy_d = 1'b0;                // word dropped, restart from idle
        end
        else if (ack_seen)
        begin
            // parked target wins inside pc_gen when discard is set
            o_src     = (i_pred_taken & ~discard_q) ? SRC_PRED : SRC_SEQ;
            discard_d = 1'b0;
            busy_d    = ~i_buf_full;          // back to back if a slot is left
        end
        else if (!busy_q && !i_buf_full)
        begin
            busy_d    = 1'b1;                 // start from idle
            discard_d = 1'b0;
            if (discard_q)
                o_src = SRC_SEQ;              // load the parked redirect pc
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            busy_q    <= 1'b0;
            discard_q <= 1'b0;
        end
        else
        begin
            busy_q    <= busy_d;
            discard_q <= discard_d;
        end
    end

    // classic cycle, one beat per cycle so stb follows cyc
    assign o_wb_cyc = busy_q;
    assign o_wb_stb = busy_q;

endmodule

//--- common/fetch_pkg.sv
package fetch_pkg;

`include "fetch_macros.svh"

    // --------------------------------------------------
    // next pc selection, fetch_ctrl -> pc_gen
    // --------------------------------------------------
    typedef enum logic [1:0] {
        SRC_HOLD  = 2'd0,  // keep the current fetch address
        SRC_SEQ   = 2'd1,  // pc + 4, or a parked redirect target
        SRC_PRED  = 2'd2,  // predicted taken target
        SRC_REDIR = 2'd3   // park the redirect target from execute
    } fetch_src_e;

    // one buffer entry is {pc, instruction, predicted taken}
    localparam int FETCH_ENTRY_W = 2 * `XLEN + 1;

endpackage

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

    // --------------------------------------------------
    // major opcodes seen by the predecoder
    // --------------------------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // beq/bne/blt/bge/bltu/bgeu
    localparam logic [6:0] OPC_JAL    = 7'b1101111;  // unconditional pc-relative jump

    // conditional branch layout, imm[12|10:5] rs2 rs1 f3 imm[4:1|11] opc
    typedef struct packed {
        logic       imm12;     // sign bit of the offset
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } rv_btype_t;

    // jump layout, imm[20|10:1|11|19:12] rd opc
    typedef struct packed {
        logic       imm20;     // sign bit of the offset
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_jtype_t;

    // one fetched word, read either as branch or as jump
    // the opcode field sits in the same bits in both views
    typedef union packed {
        logic [31:0] raw;
        rv_btype_t   b;
        rv_jtype_t   j;
    } rv_instr_u;

endpackage

//--- common/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// --------------------------------------------------
// fetch front end sizing
// --------------------------------------------------

// word, address and instruction width of the core
`define XLEN 32

// first address fetched once reset is released
`define FETCH_RESET_ADDR 32'h0000_0100

// buffer between fetch and decode holds 2**bits entries
`define FETCH_BUF_DEPTH_BITS 2

`endif
